// File: hdl/branchResolver.sv
`timescale 1ns/1ns
`default_nettype none

`include "mipsDecode_consts.svh"

module branchResolver
    import mipsDecodePkg::*;
(
    input  decodeCtrl_t decoded,
    input  regData_t    rsValue,
    input  regData_t    rtValue,
    output pcSrc_t      pcSrc,
    output logic        nextIsDelay
);

    logic rsEqRt;
    logic rsZero;
    logic rsNeg;
    logic taken;

    assign rsEqRt = (rsValue == rtValue);

    // Signed compare against zero needs only sign and zero detect
    assign rsZero = (rsValue == '0);
    assign rsNeg  = rsValue[31];

    always_comb begin
        case (decoded.branchKind)
            `BR_EQ:  taken = rsEqRt;
            `BR_NE:  taken = !rsEqRt;
            `BR_GTZ: taken = !rsNeg && !rsZero;
            `BR_LEZ: taken = rsNeg || rsZero;
            `BR_GEZ: taken = !rsNeg;
            `BR_LTZ: taken = rsNeg;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        if (decoded.isJump) begin
            pcSrc = `PC_JUMP;
        end else if (decoded.jumpReg) begin
            pcSrc = `PC_JREG;
        end else if (decoded.isBranch && taken) begin
            pcSrc = `PC_BRANCH;
        end else begin
            pcSrc = `PC_SEQ;
        end
    end

    // Delay slot always executes, taken or not
    assign nextIsDelay = decoded.isBranch || decoded.isJump || decoded.jumpReg;

    always_comb begin
        assert final (!(decoded.isBranch && decoded.isJump))
            else $error("branchResolver: instruction decoded as both branch and jump");
    end

endmodule

`default_nettype wire

// File: hdl/controlPipe.sv
`timescale 1ns/1ns
`default_nettype none

module controlPipe
    import mipsDecodePkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  logic     stall,
    input  exCtrl_t  exIn,
    output exCtrl_t  exCtrl,
    output memCtrl_t memCtrl,
    output wbCtrl_t  wbCtrl
);

    exCtrl_t  exStage;
    memCtrl_t memStage;
    wbCtrl_t  wbStage;

    // ID/EX register
    always_ff @(posedge clock) begin
        if (reset) begin
            exStage <= '0;
        end else begin
            exStage <= exIn;
        end
    end

    // EX/MEM keeps the memory and write-back fields
    always_ff @(posedge clock) begin
        if (reset) begin
            memStage <= '0;
        end else begin
            memStage <= exStage.mem;
        end
    end

    // MEM/WB keeps only write-back
    always_ff @(posedge clock) begin
        if (reset) begin
            wbStage <= '0;
        end else begin
            wbStage <= memStage.wb;
        end
    end

    assign exCtrl  = exStage;
    assign memCtrl = memStage;
    assign wbCtrl  = wbStage;

    // Read and write to memory in one slot cannot come from the decoder
    memAccessExclusive: assert property (
        @(posedge clock) disable iff (reset)
        !(memCtrl.memRead && memCtrl.memWrite)
    ) else $error("controlPipe: memRead and memWrite both set");

    // Stalled decode reaches EX as a bubble
    stallBubble: assert property (
        @(posedge clock) disable iff (reset)
        stall |=> (exCtrl == '0)
    ) else $error("controlPipe: EX not empty after stall");

endmodule

`default_nettype wire

// File: hdl/mipsDecode.sv
`timescale 1ns/1ns
`default_nettype none

module mipsDecode
    import mipsDecodePkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  logic       stall,
    input  instrWord_t instruction,
    input  regData_t   rsValue,
    input  regData_t   rtValue,
    output pcSrc_t     pcSrc,
    output logic       nextIsDelay,
    output exCtrl_t    exCtrl,
    output memCtrl_t   memCtrl,
    output wbCtrl_t    wbCtrl
);

    decodeCtrl_t decoded;

    // Decode stage
    opcodeDecoder decoder (
        .instruction (instruction),
        .stall       (stall),
        .decoded     (decoded)
    );

    // Branches resolve in decode, same cycle
    branchResolver resolver (
        .decoded     (decoded),
        .rsValue     (rsValue),
        .rtValue     (rtValue),
        .pcSrc       (pcSrc),
        .nextIsDelay (nextIsDelay)
    );

    // EX, MEM and WB control registers
    controlPipe pipe (
        .clock   (clock),
        .reset   (reset),
        .stall   (stall),
        .exIn    (decoded.ex),
        .exCtrl  (exCtrl),
        .memCtrl (memCtrl),
        .wbCtrl  (wbCtrl)
    );

endmodule

`default_nettype wire

// File: hdl/mipsDecodePkg.sv
`default_nettype none

package mipsDecodePkg;

    typedef logic [31:0] instrWord_t;
    typedef logic [31:0] regData_t;
    typedef logic [3:0]  aluOp_t;
    typedef logic [1:0]  pcSrc_t;

    // Write-back stage control
    typedef struct packed {
        logic regWrite;
        logic memToReg;
    } wbCtrl_t;

    // Memory stage control, carries WB along
    typedef struct packed {
        logic    memRead;
        logic    memWrite;
        logic    memByte;
        logic    memHalf;
        logic    memSignExtend;
        wbCtrl_t wb;
    } memCtrl_t;

    // Execute stage control
    typedef struct packed {
        aluOp_t   aluOp;
        logic     aluSrcImm;
        logic     regDst;
        // Write return address instead of ALU result
        logic     link;
        logic     signExtend;
        memCtrl_t mem;
    } exCtrl_t;

    // Everything the decoder produces; the
    // branch and jump fields die in decode
    typedef struct packed {
        exCtrl_t    ex;
        logic       isBranch;
        logic       isJump;
        logic       jumpReg;
        logic [2:0] branchKind;
    } decodeCtrl_t;

endpackage

`default_nettype wire

// File: hdl/mipsDecode_consts.svh
`ifndef MIPS_DECODE_CONSTS_SVH
`define MIPS_DECODE_CONSTS_SVH

// Primary opcodes, instruction[31:26]
`define OP_RTYPE   6'h00
`define OP_REGIMM  6'h01
`define OP_J       6'h02
`define OP_JAL     6'h03
`define OP_BEQ     6'h04
`define OP_BNE     6'h05
`define OP_BLEZ    6'h06
`define OP_BGTZ    6'h07
`define OP_ADDIU   6'h09
`define OP_SLTI    6'h0a
`define OP_SLTIU   6'h0b
`define OP_ANDI    6'h0c
`define OP_ORI     6'h0d
`define OP_XORI    6'h0e
`define OP_LUI     6'h0f
`define OP_LB      6'h20
`define OP_LH      6'h21
`define OP_LW      6'h23
`define OP_LBU     6'h24
`define OP_LHU     6'h25
`define OP_SB      6'h28
`define OP_SH      6'h29
`define OP_SW      6'h2b

// R-type function codes, instruction[5:0]
`define FUNCT_SLL  6'h00
`define FUNCT_SRL  6'h02
`define FUNCT_SRA  6'h03
`define FUNCT_JR   6'h08
`define FUNCT_JALR 6'h09
`define FUNCT_ADDU 6'h21
`define FUNCT_SUBU 6'h23
`define FUNCT_AND  6'h24
`define FUNCT_OR   6'h25
`define FUNCT_XOR  6'h26
`define FUNCT_NOR  6'h27
`define FUNCT_SLT  6'h2a
`define FUNCT_SLTU 6'h2b

// REGIMM rt field codes
`define RT_BLTZ    5'h00
`define RT_BGEZ    5'h01

// ALU operations
`define ALU_ADDU   4'd0
`define ALU_SUBU   4'd1
`define ALU_AND    4'd2
`define ALU_OR     4'd3
`define ALU_XOR    4'd4
`define ALU_NOR    4'd5
`define ALU_SLT    4'd6
`define ALU_SLTU   4'd7
`define ALU_SLL    4'd8
`define ALU_SRL    4'd9
`define ALU_SRA    4'd10
`define ALU_SLLC   4'd11

// Next PC selection
`define PC_SEQ     2'd0
`define PC_JREG    2'd1
`define PC_BRANCH  2'd2
`define PC_JUMP    2'd3

// Branch conditions, all on rs (eq/ne also use rt)
`define BR_EQ      3'd0
`define BR_NE      3'd1
`define BR_GTZ     3'd2
`define BR_LEZ     3'd3
`define BR_GEZ     3'd4
`define BR_LTZ     3'd5

`endif

// File: hdl/opcodeDecoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "mipsDecode_consts.svh"

module opcodeDecoder
    import mipsDecodePkg::*;
(
    input  instrWord_t  instruction,
    input  logic        stall,
    output decodeCtrl_t decoded
);

    logic [5:0]  opcode;
    logic [4:0]  rt;
    logic [5:0]  funct;
    logic        known;
    logic        zeroExtend;
    decodeCtrl_t ctrl;

    assign opcode = instruction[31:26];
    assign rt     = instruction[20:16];
    assign funct  = instruction[5:0];

    // Logical immediates and lui take a zero-extended immediate
    assign zeroExtend = (opcode == `OP_ANDI) || (opcode == `OP_ORI) ||
                        (opcode == `OP_XORI) || (opcode == `OP_LUI);

    // Register-register op, result to rd
    function automatic exCtrl_t aluReg(input aluOp_t op);
        exCtrl_t ex;
        ex = '0;
        ex.aluOp = op;
        ex.regDst = 1'b1;
        ex.mem.wb.regWrite = 1'b1;
        return ex;
    endfunction

    // Immediate op, result to rt
    function automatic exCtrl_t aluImm(input aluOp_t op);
        exCtrl_t ex;
        ex = '0;
        ex.aluOp = op;
        ex.aluSrcImm = 1'b1;
        ex.mem.wb.regWrite = 1'b1;
        return ex;
    endfunction

    // Load or store, address is base plus offset
    function automatic exCtrl_t memAccess(input logic load, input logic byteSize,
                                          input logic halfSize, input logic signedLoad);
        exCtrl_t ex;
        ex = '0;
        ex.aluOp = `ALU_ADDU;
        ex.aluSrcImm = 1'b1;
        ex.mem.memRead = load;
        ex.mem.memWrite = !load;
        ex.mem.memByte = byteSize;
        ex.mem.memHalf = halfSize;
        ex.mem.memSignExtend = signedLoad;
        ex.mem.wb.regWrite = load;
        ex.mem.wb.memToReg = load;
        return ex;
    endfunction

    // Branches write nothing
    function automatic decodeCtrl_t branchCtrl(input logic [2:0] kind);
        decodeCtrl_t d;
        d = '0;
        d.isBranch = 1'b1;
        d.branchKind = kind;
        return d;
    endfunction

    always_comb begin
        ctrl = '0;
        known = 1'b1;
        case (opcode)
            `OP_RTYPE: begin
                case (funct)
                    `FUNCT_ADDU: ctrl.ex = aluReg(`ALU_ADDU);
                    `FUNCT_SUBU: ctrl.ex = aluReg(`ALU_SUBU);
                    `FUNCT_AND:  ctrl.ex = aluReg(`ALU_AND);
                    `FUNCT_OR:   ctrl.ex = aluReg(`ALU_OR);
                    `FUNCT_XOR:  ctrl.ex = aluReg(`ALU_XOR);
                    `FUNCT_NOR:  ctrl.ex = aluReg(`ALU_NOR);
                    `FUNCT_SLT:  ctrl.ex = aluReg(`ALU_SLT);
                    `FUNCT_SLTU: ctrl.ex = aluReg(`ALU_SLTU);
                    `FUNCT_SLL:  ctrl.ex = aluReg(`ALU_SLL);
                    `FUNCT_SRL:  ctrl.ex = aluReg(`ALU_SRL);
                    `FUNCT_SRA:  ctrl.ex = aluReg(`ALU_SRA);
                    `FUNCT_JR:   ctrl.jumpReg = 1'b1;
                    `FUNCT_JALR: begin
                        // Return address goes to rd
                        ctrl.ex = aluReg(`ALU_ADDU);
                        ctrl.ex.link = 1'b1;
                        ctrl.jumpReg = 1'b1;
                    end
                    default: known = 1'b0;
                endcase
            end
            `OP_REGIMM: begin
                case (rt)
                    `RT_BGEZ: ctrl = branchCtrl(`BR_GEZ);
                    `RT_BLTZ: ctrl = branchCtrl(`BR_LTZ);
                    default:  known = 1'b0;
                endcase
            end
            `OP_BEQ:   ctrl = branchCtrl(`BR_EQ);
            `OP_BNE:   ctrl = branchCtrl(`BR_NE);
            `OP_BGTZ:  ctrl = branchCtrl(`BR_GTZ);
            `OP_BLEZ:  ctrl = branchCtrl(`BR_LEZ);
            `OP_J:     ctrl.isJump = 1'b1;
            `OP_JAL: begin
                ctrl.ex.aluOp = `ALU_ADDU;
                ctrl.ex.link = 1'b1;
                ctrl.ex.mem.wb.regWrite = 1'b1;
                ctrl.isJump = 1'b1;
            end
            `OP_ADDIU: ctrl.ex = aluImm(`ALU_ADDU);
            `OP_SLTI:  ctrl.ex = aluImm(`ALU_SLT);
            `OP_SLTIU: ctrl.ex = aluImm(`ALU_SLTU);
            `OP_ANDI:  ctrl.ex = aluImm(`ALU_AND);
            `OP_ORI:   ctrl.ex = aluImm(`ALU_OR);
            `OP_XORI:  ctrl.ex = aluImm(`ALU_XOR);
            `OP_LUI:   ctrl.ex = aluImm(`ALU_SLLC);
            // load, byte, half, signed
            `OP_LW:    ctrl.ex = memAccess(1'b1, 1'b0, 1'b0, 1'b1);
            `OP_LH:    ctrl.ex = memAccess(1'b1, 1'b0, 1'b1, 1'b1);
            `OP_LHU:   ctrl.ex = memAccess(1'b1, 1'b0, 1'b1, 1'b0);
            `OP_LB:    ctrl.ex = memAccess(1'b1, 1'b1, 1'b0, 1'b1);
            `OP_LBU:   ctrl.ex = memAccess(1'b1, 1'b1, 1'b0, 1'b0);
            `OP_SW:    ctrl.ex = memAccess(1'b0, 1'b0, 1'b0, 1'b0);
            `OP_SH:    ctrl.ex = memAccess(1'b0, 1'b0, 1'b1, 1'b0);
            `OP_SB:    ctrl.ex = memAccess(1'b0, 1'b1, 1'b0, 1'b0);
            default:   known = 1'b0;
        endcase

        ctrl.ex.signExtend = known && !zeroExtend;

        // Stalled or undecodable words become a bubble
        decoded = (stall || !known) ? '0 : ctrl;
    end

    always_comb begin
        assert final (!(decoded.ex.mem.memByte && decoded.ex.mem.memHalf))
            else $error("opcodeDecoder: byte and half access both set for %h", instruction);
    end

endmodule

`default_nettype wire

// File: mipsDecode.f
+incdir+hdl
hdl/mipsDecodePkg.sv
hdl/opcodeDecoder.sv
hdl/branchResolver.sv
hdl/controlPipe.sv
hdl/mipsDecode.sv
test/clockGen.sv
test/mipsDecodeTb.sv

// File: test/clockGen.sv
`timescale 1ns/1ns
`default_nettype none

module clockGen #(
    parameter int period = 20
) (
    output logic clock
);

    // Free-running, starts low
    initial begin
        clock = 1'b0;
        forever #(period / 2) clock = ~clock;
    end

endmodule

`default_nettype wire

// File: test/mipsDecodeTb.sv
`timescale 1ns/1ns
`default_nettype none

`include "mipsDecode_consts.svh"

module mipsDecodeTb
    import mipsDecodePkg::*;
();

    localparam int resetCycles = 4;
    localparam int aluCount = 120;
    localparam int memCount = 80;
    localparam int branchCount = 140;
    localparam int jumpCount = 40;
    localparam int stallCount = 60;
    localparam int undefCount = 60;
    localparam int stimCycles = aluCount + memCount + branchCount + jumpCount +
                                stallCount + undefCount;
    // Reset, stimulus and drain plus margin
    localparam int timeoutCycles = resetCycles + stimCycles + 196;

    // Expected control tables
    localparam logic [5:0] rFuncts [11] = '{`FUNCT_ADDU, `FUNCT_SUBU, `FUNCT_AND, `FUNCT_OR,
        `FUNCT_XOR, `FUNCT_NOR, `FUNCT_SLT, `FUNCT_SLTU, `FUNCT_SLL, `FUNCT_SRL, `FUNCT_SRA};
    localparam aluOp_t rAlu [11] = '{`ALU_ADDU, `ALU_SUBU, `ALU_AND, `ALU_OR, `ALU_XOR,
        `ALU_NOR, `ALU_SLT, `ALU_SLTU, `ALU_SLL, `ALU_SRL, `ALU_SRA};
    localparam logic [5:0] iOps [7] = '{`OP_ADDIU, `OP_SLTI, `OP_SLTIU, `OP_ANDI, `OP_ORI,
        `OP_XORI, `OP_LUI};
    localparam aluOp_t iAlu [7] = '{`ALU_ADDU, `ALU_SLT, `ALU_SLTU, `ALU_AND, `ALU_OR,
        `ALU_XOR, `ALU_SLLC};
    localparam logic [5:0] memOps [8] = '{`OP_LW, `OP_LH, `OP_LHU, `OP_LB, `OP_LBU,
        `OP_SW, `OP_SH, `OP_SB};
    // read write byte half signed, then regWrite memToReg
    localparam logic [6:0] memBits [8] = '{7'b10001_11, 7'b10011_11, 7'b10010_11,
        7'b10101_11, 7'b10100_11, 7'b01000_00, 7'b01010_00, 7'b01100_00};

    logic       clock;
    logic       reset;
    logic       stall;
    instrWord_t instruction;
    regData_t   rsValue;
    regData_t   rtValue;
    pcSrc_t     pcSrc;
    logic       nextIsDelay;
    exCtrl_t    exCtrl;
    memCtrl_t   memCtrl;
    wbCtrl_t    wbCtrl;

    // Reference pipe state
    exCtrl_t    curEx;
    exCtrl_t    expEx;
    memCtrl_t   expMem;
    wbCtrl_t    expWb;
    pcSrc_t     expPcSrc;
    logic       expDelay;
    logic       checking = 1'b0;
    int         cycles = 0;
    int         seed;

    clockGen #(.period(20)) clockSource (.clock(clock));

    mipsDecode UUT (
        .clock       (clock),
        .reset       (reset),
        .stall       (stall),
        .instruction (instruction),
        .rsValue     (rsValue),
        .rtValue     (rtValue),
        .pcSrc       (pcSrc),
        .nextIsDelay (nextIsDelay),
        .exCtrl      (exCtrl),
        .memCtrl     (memCtrl),
        .wbCtrl      (wbCtrl)
    );

    function automatic int unsigned randBelow(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic instrWord_t randWord();
        return $random(seed);
    endfunction

    // Zero, all ones, negative and positive values show up often
    function automatic regData_t pickOperand();
        regData_t r;
        r = randWord();
        case (randBelow(6))
            0: return '0;
            1: return '1;
            2: return {1'b1, r[30:0]};
            3: return 32'd1;
            4: return {1'b0, r[30:0]};
            default: return r;
        endcase
    endfunction

    function automatic instrWord_t aluWord(input int unsigned idx, input instrWord_t r);
        if (idx < 11) begin
            return {`OP_RTYPE, r[25:6], rFuncts[idx]};
        end
        return {iOps[idx - 11], r[25:0]};
    endfunction

    // Index order beq bne blez bgtz bgez bltz j jal jr jalr
    function automatic instrWord_t flowWord(input int unsigned idx, input instrWord_t r);
        case (idx)
            0: return {`OP_BEQ, r[25:0]};
            1: return {`OP_BNE, r[25:0]};
            2: return {`OP_BLEZ, r[25:0]};
            3: return {`OP_BGTZ, r[25:0]};
            4: return {`OP_REGIMM, r[25:21], `RT_BGEZ, r[15:0]};
            5: return {`OP_REGIMM, r[25:21], `RT_BLTZ, r[15:0]};
            6: return {`OP_J, r[25:0]};
            7: return {`OP_JAL, r[25:0]};
            8: return {`OP_RTYPE, r[25:6], `FUNCT_JR};
            default: return {`OP_RTYPE, r[25:6], `FUNCT_JALR};
        endcase
    endfunction

    // Packed as aluOp, imm regDst link sext, memory bits, regWrite memToReg
    function automatic exCtrl_t expectedEx(input instrWord_t w);
        exCtrl_t e;
        int k;
        e = '0;
        for (k = 0; k < 11; k++) begin
            if (w[31:26] == `OP_RTYPE && w[5:0] == rFuncts[k]) e = {rAlu[k], 4'b0101, 7'b10};
        end
        for (k = 0; k < 7; k++) begin
            if (w[31:26] == iOps[k]) e = {iAlu[k], 3'b100, k < 3, 7'b10};
        end
        for (k = 0; k < 8; k++) begin
            if (w[31:26] == memOps[k]) e = {`ALU_ADDU, 4'b1001, memBits[k]};
        end
        case (w[31:26])
            `OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ, `OP_J: e = {`ALU_ADDU, 4'b0001, 7'b0};
            `OP_JAL: e = {`ALU_ADDU, 4'b0011, 7'b10};
            `OP_REGIMM: begin
                if (w[20:16] == `RT_BGEZ || w[20:16] == `RT_BLTZ) e = {`ALU_ADDU, 4'b0001, 7'b0};
            end
            `OP_RTYPE: begin
                if (w[5:0] == `FUNCT_JR) e = {`ALU_ADDU, 4'b0001, 7'b0};
                if (w[5:0] == `FUNCT_JALR) e = {`ALU_ADDU, 4'b0111, 7'b10};
            end
            default: ;
        endcase
        return e;
    endfunction

    // Returns {nextIsDelay, pcSrc}
    function automatic logic [2:0] expectedFlow(input instrWord_t w, input regData_t rs,
                                                input regData_t rt, input logic st);
        logic   cond;
        logic   isFlow;
        pcSrc_t target;
        cond = 1'b1;
        isFlow = 1'b1;
        target = `PC_BRANCH;
        case (w[31:26])
            `OP_BEQ:  cond = (rs == rt);
            `OP_BNE:  cond = (rs != rt);
            `OP_BLEZ: cond = ($signed(rs) <= 0);
            `OP_BGTZ: cond = ($signed(rs) > 0);
            `OP_REGIMM: begin
                isFlow = (w[20:16] == `RT_BGEZ) || (w[20:16] == `RT_BLTZ);
                cond = (w[20:16] == `RT_BGEZ) ? ($signed(rs) >= 0) : ($signed(rs) < 0);
            end
            `OP_J, `OP_JAL: target = `PC_JUMP;
            `OP_RTYPE: begin
                isFlow = (w[5:0] == `FUNCT_JR) || (w[5:0] == `FUNCT_JALR);
                target = `PC_JREG;
            end
            default: isFlow = 1'b0;
        endcase
        if (st || !isFlow) begin
            return {1'b0, `PC_SEQ};
        end
        return {1'b1, cond ? target : `PC_SEQ};
    endfunction

    task automatic issue(input instrWord_t w, input regData_t rs, input regData_t rt,
                         input logic st);
        @(posedge clock);
        instruction <= w;
        rsValue <= rs;
        rtValue <= rt;
        stall <= st;
        curEx <= st ? '0 : expectedEx(w);
        {expDelay, expPcSrc} <= expectedFlow(w, rs, rt, st);
    endtask

    task automatic valueFail(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, expected, actual);
        $display("TB FAILED");
        $fatal(1, "Wrong value on %s", name);
    endtask

    task automatic failWithReason(input string what);
        $display("t=%0t %s", $time, what);
        $display("TB FAILED");
        $fatal(1, "%s", what);
    endtask

    // Expected EX, MEM and WB history
    always @(posedge clock) begin
        checking <= 1'b1;
        if (reset) begin
            expEx <= '0;
            expMem <= '0;
            expWb <= '0;
        end else begin
            expEx <= curEx;
            expMem <= expEx.mem;
            expWb <= expMem.wb;
        end
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= timeoutCycles) begin
            failWithReason("Timeout, the stimulus did not finish in time");
        end
    end

    pcSrcCheck: assert property (@(posedge clock) checking |-> pcSrc == expPcSrc)
        else valueFail("pcSrc", $sampled(expPcSrc), $sampled(pcSrc));
    delayCheck: assert property (@(posedge clock) checking |-> nextIsDelay == expDelay)
        else valueFail("nextIsDelay", $sampled(expDelay), $sampled(nextIsDelay));
    exCheck: assert property (@(posedge clock) checking |-> exCtrl == expEx)
        else valueFail("exCtrl", $sampled(expEx), $sampled(exCtrl));
    memCheck: assert property (@(posedge clock) checking |-> memCtrl == expMem)
        else valueFail("memCtrl", $sampled(expMem), $sampled(memCtrl));
    wbCheck: assert property (@(posedge clock) checking |-> wbCtrl == expWb)
        else valueFail("wbCtrl", $sampled(expWb), $sampled(wbCtrl));
    stallQuiet: assert property (@(posedge clock)
        checking && stall |-> pcSrc == `PC_SEQ && !nextIsDelay)
        else failWithReason("Stalled decode still redirected the PC or flagged a delay slot");
    stallBubble: assert property (@(posedge clock) checking && stall |=> exCtrl == '0)
        else failWithReason("Stall did not put a bubble into EX");
    resetClear: assert property (@(posedge clock)
        checking && reset |=> exCtrl == '0 && memCtrl == '0 && wbCtrl == '0)
        else failWithReason("Pipe control was not cleared by reset");

    initial begin
        instrWord_t w;
        regData_t   a;
        int         i;
        seed = 32'h94f8_4252;
        reset = 1'b1;
        stall = 1'b0;
        // A load sits on the bus during reset so the pipe has control to clear
        instruction = {`OP_LW, 26'h0};
        rsValue = '0;
        rtValue = '0;
        curEx = expectedEx(instruction);
        expPcSrc = `PC_SEQ;
        expDelay = 1'b0;
        repeat (resetCycles) @(posedge clock);
        reset <= 1'b0;
        for (i = 0; i < aluCount; i++) begin
            issue(aluWord(randBelow(18), randWord()), randWord(), randWord(), 1'b0);
        end
        for (i = 0; i < memCount; i++) begin
            w = randWord();
            issue({memOps[randBelow(8)], w[25:0]}, randWord(), randWord(), 1'b0);
        end
        // Equal operands in about a third of the branches
        for (i = 0; i < branchCount; i++) begin
            a = pickOperand();
            issue(flowWord(randBelow(6), randWord()), a,
                  (randBelow(3) == 0) ? a : pickOperand(), 1'b0);
        end
        for (i = 0; i < jumpCount; i++) begin
            issue(flowWord(6 + randBelow(4), randWord()), pickOperand(), pickOperand(), 1'b0);
        end
        // Mixed traffic with stall high one cycle in three
        for (i = 0; i < stallCount; i++) begin
            w = (randBelow(2) == 0) ? aluWord(randBelow(18), randWord()) :
                                      flowWord(randBelow(10), randWord());
            issue(w, pickOperand(), pickOperand(), randBelow(3) == 0);
        end
        // Undefined words biased toward bad funct and rt fields
        i = 0;
        while (i < undefCount) begin
            w = randWord();
            if (randBelow(2) == 0) begin
                w[31:26] = 6'(randBelow(2));
            end
            if (expectedEx(w) == '0) begin
                issue(w, pickOperand(), pickOperand(), 1'b0);
                i++;
            end
        end
        repeat (4) issue('1, '0, '0, 1'b0);
        @(negedge clock);
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire
